/* Makefile */
TOP = tbMips2Oisc
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* all.f */
+incdir+.
mipsPkg.sv
oiscPkg.sv
mipsDecoder.sv
moveSequencer.sv
moveMerger.sv
mips2Oisc.sv
tbClockGen.sv
mips2Oisc_checker.sv
tbMips2Oisc.sv

/* mips2Oisc.sv */
`include "xlate_cfg.svh"

module mips2Oisc (
  input  logic             CLK,
  input  logic             RST,
  input  logic             instValid,
  input  mipsPkg::mipsWord instData,
  output logic             instCredit,
  output logic             moveValid,
  output oiscPkg::oiscMove moveData,
  input  logic             moveCredit
);
  import oiscPkg::*;

  logic [`LANE_COUNT-1:0] laneLoad;
  xlateJob                laneJob;
  logic [`LANE_COUNT-1:0] seqPending;
  oiscMove                seqMove [`LANE_COUNT];
  logic [`LANE_COUNT-1:0] seqDone;
  logic [`LANE_COUNT-1:0] laneGrant;

  mipsDecoder i_decoder (
    .CLK        (CLK),
    .RST        (RST),
    .instValid  (instValid),
    .instData   (instData),
    .laneLoad   (laneLoad),
    .laneJob    (laneJob),
    .laneDone   (seqDone),
    .instCredit (instCredit)
  );

  // Every lane sees the job and laneLoad picks the taker
  for (genvar g = 0; g < `LANE_COUNT; g++) begin : genLane
    moveSequencer i_seq (
      .CLK     (CLK),
      .RST     (RST),
      .load    (laneLoad[g]),
      .job     (laneJob),
      .grant   (laneGrant[g]),
      .move    (seqMove[g]),
      .pending (seqPending[g]),
      .done    (seqDone[g])
    );
  end

  moveMerger i_merger (
    .CLK         (CLK),
    .RST         (RST),
    .lanePending (seqPending),
    .laneMove    (seqMove),
    .laneDone    (seqDone),
    .laneGrant   (laneGrant),
    .moveValid   (moveValid),
    .moveData    (moveData),
    .moveCredit  (moveCredit)
  );

endmodule

/* mips2Oisc_checker.sv */
`include "xlate_cfg.svh"

module mips2Oisc_checker (
  input  logic                   CLK,
  input  logic                   RST,
  input  oiscPkg::creditCount    creditCnt,
  input  logic [`LANE_COUNT-1:0] laneGrant,
  input  logic                   moveValid,
  input  oiscPkg::oiscMove       moveData
);

  resetQuiet: assert property (@(posedge CLK) RST |-> !moveValid)
    else $error("moveValid is high while reset is held");

  // Credit counter at zero blocks every lane
  noGrantWithoutCredit: assert property (@(posedge CLK) disable iff (RST)
      (creditCnt == '0) |-> (laneGrant == '0))
    else $error("Merger granted a move with no output credit left");

  knownData: assert property (@(posedge CLK) disable iff (RST)
      moveValid |-> !$isunknown(moveData))
    else $error("moveData has unknown bits while moveValid is high");

endmodule

bind moveMerger mips2Oisc_checker i_checker (
  .CLK       (CLK),
  .RST       (RST),
  .creditCnt (creditCnt),
  .laneGrant (laneGrant),
  .moveValid (moveValid),
  .moveData  (moveData)
);

/* mips2Oisc_stimulus.txt */
# Columns: tag (I = instruction to send, E = next expected move), test name, hex value
# An E value holds the move source in bits 31:16 and the destination in bits 15:0
I logic 00851024
E logic 00240110
E logic 00250111
E logic 01100022
I logic 00C71825
E logic 00260120
E logic 00270121
E logic 01200023
I logic 01095026
E logic 00280130
E logic 00290131
E logic 0130002A
I logic 016C6827
E logic 002B0140
E logic 002C0141
E logic 0140002D
I logic 30858001
E logic 00240110
E logic 80010010
E logic 00100111
E logic 01100025
I logic 3422FFFF
E logic 00210120
E logic FFFF0010
E logic 00100121
E logic 01200022
I logic 387F1234
E logic 00230130
E logic 12340010
E logic 00100131
E logic 0130003F
I arith 00853020
E arith 00240100
E arith 00250101
E arith 00010102
E arith 01000026
I arith 00E84821
E arith 00270100
E arith 00280101
E arith 00000102
E arith 01000029
I arith 014B6022
E arith 002A0100
E arith 002B0101
E arith 00030102
E arith 0100002C
I arith 01AE7823
E arith 002D0100
E arith 002E0101
E arith 00020102
E arith 0100002F
I arith 2085FFF0
E arith 00240100
E arith FFF00010
E arith 00100101
E arith 00010102
E arith 01000025
I arith 24430042
E arith 00220100
E arith 00420010
E arith 00100101
E arith 00000102
E arith 01000023
I arith 00221804
E arith 00210150
E arith 00220151
E arith 00020152
E arith 01500023
I arith 00853006
E arith 00240150
E arith 00250151
E arith 00000152
E arith 01500026
I arith 00E84807
E arith 00270150
E arith 00280151
E arith 00010152
E arith 01500029
I arith 000A5940
E arith 002A0150
E arith 00050010
E arith 00100151
E arith 00020152
E arith 0150002B
I arith 000C6FC2
E arith 002C0150
E arith 001F0010
E arith 00100151
E arith 00000152
E arith 0150002D
I arith 000E7843
E arith 002E0150
E arith 00010010
E arith 00100151
E arith 00010152
E arith 0150002F
I moveload 00002010
E moveload 00080024
I moveload 00002812
E moveload 00090025
I moveload 00C00011
E moveload 00260008
I moveload 00E00013
E moveload 00270009
I moveload 8085FFFC
E moveload 00240200
E moveload FFFC0201
E moveload 000C0202
E moveload 02030025
I moveload 90C70010
E moveload 00260200
E moveload 00100201
E moveload 00080202
E moveload 02030027
I moveload 85090002
E moveload 00280200
E moveload 00020201
E moveload 000D0202
E moveload 02030029
I moveload 954B8000
E moveload 002A0200
E moveload 80000201
E moveload 00090202
E moveload 0203002B
I moveload 8FBF0004
E moveload 003D0200
E moveload 00040201
E moveload 000A0202
E moveload 0203003F
I trap 10850003
E trap FFFF000F
I trap AFBF0008
E trap FFFF000F
I trap 0000000C
E trap FFFF000F
I trap 00221821
E trap 00210100
E trap 00220101
E trap 00000102
E trap 01000023
I backpressure 00221825
E backpressure 00210120
E backpressure 00220121
E backpressure 01200023
I backpressure 00004012
E backpressure 00090028
I backpressure 00032083
E backpressure 00230150
E backpressure 00020010
E backpressure 00100151
E backpressure 00010152
E backpressure 01500024
I backpressure 8C430100
E backpressure 00220200
E backpressure 01000201
E backpressure 000A0202
E backpressure 02030023
I backpressure 0000000D
E backpressure FFFF000F

/* mipsDecoder.sv */
`include "xlate_cfg.svh"

module mipsDecoder (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   instValid,
  input  mipsPkg::mipsWord       instData,
  output logic [`LANE_COUNT-1:0] laneLoad,
  output oiscPkg::xlateJob       laneJob,
  input  logic [`LANE_COUNT-1:0] laneDone,
  output logic                   instCredit
);
  import mipsPkg::*;
  import oiscPkg::*;

  mipsRType   fields;
  mipsImm     imm16;
  seqKind     kind;
  logic       isSpecial;
  logic       isShift;
  logic [1:0] opSel;
  oiscAddr    rsAddr;
  oiscAddr    rtAddr;
  oiscAddr    rdAddr;
  oiscAddr    ctrlUnit;
  oiscAddr    ctrlCode;
  xlateJob    job;
  laneIdx     loadPtr;

  function automatic oiscAddr gprAddr(input mipsReg r);
    return `GPR_BASE + oiscAddr'(r);
  endfunction

  function automatic oiscAddr logicUnit(input logic [1:0] sel);
    case (sel)
      2'b00:   return `AND_UNIT;
      2'b01:   return `OR_UNIT;
      2'b10:   return `XOR_UNIT;
      default: return `NOR_UNIT;
    endcase
  endfunction

  function automatic oiscAddr adderCtrl(input logic [1:0] sel);
    case (sel)
      2'b00:   return `ADDER_ADD;
      2'b01:   return `ADDER_ADDU;
      2'b10:   return `ADDER_SUB;
      default: return `ADDER_SUBU;
    endcase
  endfunction

  function automatic oiscAddr shiftCtrl(input logic [1:0] sel);
    case (sel)
      2'b00:   return `SHIFT_LEFT;
      2'b10:   return `SHIFT_RIGHT_LOG;
      default: return `SHIFT_RIGHT_ARITH;
    endcase
  endfunction

  function automatic oiscAddr loadCtrl(input logic [2:0] sel);
    case (sel)
      3'b000:  return `LOAD_LB;
      3'b100:  return `LOAD_LBU;
      3'b001:  return `LOAD_LH;
      3'b101:  return `LOAD_LHU;
      default: return `LOAD_LW;
    endcase
  endfunction

  assign fields    = instData;
  assign imm16     = instData[15:0];
  assign isSpecial = fields.opcode == 6'b000000;
  assign isShift   = isSpecial && !fields.funct[5];
  assign opSel     = isSpecial ? fields.funct[1:0] : fields.opcode[1:0];
  assign rsAddr    = gprAddr(fields.rs);
  assign rtAddr    = gprAddr(fields.rt);
  assign rdAddr    = gprAddr(fields.rd);
  assign ctrlUnit  = isShift ? `SHIFT_UNIT : `ADD_UNIT;
  assign ctrlCode  = isShift ? shiftCtrl(opSel) : adderCtrl(opSel);

  always_comb begin
    casez (instData)
      32'b000000_?????_?????_?????_00000_1001??: kind = seqLogic3R;  // AND OR XOR NOR
      32'b001100_?????_?????_????????????????,
      32'b001101_?????_?????_????????????????,
      32'b001110_?????_?????_????????????????:   kind = seqLogic2I;
      32'b000000_?????_?????_?????_00000_1000??,
      32'b000000_?????_?????_?????_00000_000100,
      32'b000000_?????_?????_?????_00000_00011?: kind = seqCtrl3R;   // Adder and variable shifts
      32'b00100?_?????_?????_????????????????,
      32'b000000_00000_?????_?????_?????_000000,
      32'b000000_00000_?????_?????_?????_00001?: kind = seqCtrl2I;
      32'b000000_00000_00000_?????_00000_0100?0,
      32'b000000_?????_00000_00000_00000_0100?1: kind = seqMove;     // HI/LO moves
      32'b100?00_?????_?????_????????????????,
      32'b100?01_?????_?????_????????????????,
      32'b100011_?????_?????_????????????????:   kind = seqLoad;
      default:                                   kind = seqTrap;
    endcase
  end

  always_comb begin
    job.kind     = kind;
    job.unitBase = `ADD_UNIT;
    job.opA      = rsAddr;
    job.opB      = rtAddr;
    job.dest     = rdAddr;
    job.imm      = imm16;
    job.ctrl     = '0;
    case (kind)
      seqLogic3R: job.unitBase = logicUnit(opSel);
      seqLogic2I: begin
        job.unitBase = logicUnit(opSel);
        job.dest     = rtAddr;
      end
      seqCtrl3R: begin
        job.unitBase = ctrlUnit;
        job.ctrl     = ctrlCode;
      end
      seqCtrl2I: begin
        job.unitBase = ctrlUnit;
        job.ctrl     = ctrlCode;
        if (isShift) begin
          job.opA = rtAddr;
          job.imm = {11'b0, fields.shamt};
        end else begin
          job.dest = rtAddr;
        end
      end
      seqMove: begin
        if (fields.funct[0])   // MTHI MTLO
          job.dest = fields.funct[1] ? `LO_ADDR : `HI_ADDR;
        else
          job.opA = fields.funct[1] ? `LO_ADDR : `HI_ADDR;
      end
      seqLoad: begin
        job.unitBase = `MMU_BASE;
        job.ctrl     = loadCtrl(fields.opcode[2:0]);
        job.dest     = rtAddr;
      end
      default: ;
    endcase
  end

  // Credits guarantee the lane under loadPtr is idle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      laneLoad   <= '0;
      loadPtr    <= '0;
      instCredit <= 1'b0;
    end else begin
      laneLoad   <= '0;
      instCredit <= |laneDone;
      if (instValid) begin
        laneLoad[loadPtr] <= 1'b1;
        loadPtr <= (loadPtr == laneIdx'(`LANE_COUNT - 1)) ? '0 : loadPtr + laneIdx'(1);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (instValid)
      laneJob <= job;
  end

endmodule

/* mipsPkg.sv */
package mipsPkg;

  typedef logic [31:0] mipsWord;
  typedef logic [4:0]  mipsReg;
  typedef logic [15:0] mipsImm;

  // R-type view of an instruction word
  typedef struct packed {
    logic [5:0] opcode;
    mipsReg     rs;
    mipsReg     rt;
    mipsReg     rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } mipsRType;

endpackage

/* moveMerger.sv */
`include "xlate_cfg.svh"

module moveMerger (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic [`LANE_COUNT-1:0] lanePending,
  input  oiscPkg::oiscMove       laneMove [`LANE_COUNT],
  input  logic [`LANE_COUNT-1:0] laneDone,
  output logic [`LANE_COUNT-1:0] laneGrant,
  output logic                   moveValid,
  output oiscPkg::oiscMove       moveData,
  input  logic                   moveCredit
);
  import oiscPkg::*;

  laneIdx     drainPtr;
  creditCount creditCnt;
  logic       grantNow;

  // Only the lane holding the oldest job may send
  assign grantNow = lanePending[drainPtr] && (creditCnt != '0);

  always_comb begin
    laneGrant           = '0;
    laneGrant[drainPtr] = grantNow;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      drainPtr <= '0;
    end else if (laneDone[drainPtr]) begin
      drainPtr <= (drainPtr == laneIdx'(`LANE_COUNT - 1)) ? '0 : drainPtr + laneIdx'(1);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST)
      creditCnt <= creditCount'(`OUT_CREDITS);
    else if (grantNow && !moveCredit)
      creditCnt <= creditCnt - creditCount'(1);
    else if (!grantNow && moveCredit)
      creditCnt <= creditCnt + creditCount'(1);
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST)
      moveValid <= 1'b0;
    else
      moveValid <= grantNow;
  end

  always_ff @(posedge CLK) begin
    if (grantNow)
      moveData <= laneMove[drainPtr];
  end

endmodule

/* moveSequencer.sv */
`include "xlate_cfg.svh"

module moveSequencer (
  input  logic             CLK,
  input  logic             RST,
  input  logic             load,
  input  oiscPkg::xlateJob job,
  input  logic             grant,
  output oiscPkg::oiscMove move,
  output logic             pending,
  output logic             done
);
  import oiscPkg::*;

  typedef enum logic {laneIdle, laneEmit} laneState;

  laneState state;
  stepIdx   step;
  stepIdx   lastStep;
  xlateJob  jobQ;
  oiscAddr  unit;
  oiscAddr  unitSecond;
  oiscAddr  unitCtrl;

  assign unit       = jobQ.unitBase;
  assign unitSecond = unit + 16'd1;
  assign unitCtrl   = unit + 16'd2;
  assign pending    = state == laneEmit;
  assign done       = grant && (step == lastStep);

  always_comb begin
    case (jobQ.kind)
      seqLogic3R: lastStep = 3'd2;
      seqLogic2I: lastStep = 3'd3;
      seqCtrl3R:  lastStep = 3'd3;
      seqCtrl2I:  lastStep = 3'd4;
      seqLoad:    lastStep = 3'd3;
      default:    lastStep = 3'd0;   // Single move
    endcase
  end

  always_comb begin
    move = '{`TRAP_SRC, `TRAP_DST};
    case (jobQ.kind)
      seqLogic3R:
        case (step)
          3'd0:    move = '{jobQ.opA, unit};
          3'd1:    move = '{jobQ.opB, unitSecond};
          default: move = '{unit, jobQ.dest};
        endcase
      seqLogic2I:
        case (step)
          3'd0:    move = '{jobQ.opA, unit};
          3'd1:    move = '{jobQ.imm, `IMM_ADDR};
          3'd2:    move = '{`IMM_ADDR, unitSecond};
          default: move = '{unit, jobQ.dest};
        endcase
      seqCtrl3R:
        case (step)
          3'd0:    move = '{jobQ.opA, unit};
          3'd1:    move = '{jobQ.opB, unitSecond};
          3'd2:    move = '{jobQ.ctrl, unitCtrl};
          default: move = '{unit, jobQ.dest};
        endcase
      seqCtrl2I:
        case (step)
          3'd0:    move = '{jobQ.opA, unit};
          3'd1:    move = '{jobQ.imm, `IMM_ADDR};
          3'd2:    move = '{`IMM_ADDR, unitSecond};
          3'd3:    move = '{jobQ.ctrl, unitCtrl};
          default: move = '{unit, jobQ.dest};
        endcase
      seqLoad:
        case (step)
          3'd0:    move = '{jobQ.opA, unit};
          3'd1:    move = '{jobQ.imm, unitSecond};
          3'd2:    move = '{jobQ.ctrl, unitCtrl};
          default: move = '{unit + 16'd3, jobQ.dest};   // MMU read data
        endcase
      seqMove: move = '{jobQ.opA, jobQ.dest};
      default: ;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= laneIdle;
      step  <= '0;
    end else if (load) begin
      state <= laneEmit;
      step  <= '0;
    end else if (done) begin
      state <= laneIdle;
      step  <= '0;
    end else if (grant) begin
      step <= step + 3'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (load)
      jobQ <= job;
  end

endmodule

/* oiscPkg.sv */
`include "xlate_cfg.svh"

package oiscPkg;

  typedef logic [15:0] oiscAddr;   // Address or literal

  typedef struct packed {
    oiscAddr src;
    oiscAddr dst;
  } oiscMove;

  typedef enum logic [2:0] {
    seqLogic3R,
    seqLogic2I,
    seqCtrl3R,
    seqCtrl2I,
    seqMove,
    seqLoad,
    seqTrap
  } seqKind;

  // Everything a lane needs to emit one instruction
  typedef struct packed {
    seqKind  kind;
    oiscAddr unitBase;
    oiscAddr opA;
    oiscAddr opB;
    oiscAddr dest;
    oiscAddr imm;
    oiscAddr ctrl;
  } xlateJob;

  typedef logic [$clog2(`LANE_COUNT)-1:0]    laneIdx;
  typedef logic [$clog2(`OUT_CREDITS+1)-1:0] creditCount;
  typedef logic [2:0]                        stepIdx;   // Up to five moves

endpackage

/* tbClockGen.sv */
module tbClockGen (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;   // Period 20
  end

  // Reset rises just after time zero so the asynchronous reset sees an edge
  initial begin
    RST = 1'b0;
    #1 RST = 1'b1;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

/* tbMips2Oisc.sv */
`include "xlate_cfg.svh"

module tbMips2Oisc;
  import mipsPkg::*;
  import oiscPkg::*;

  typedef logic [8*16-1:0] testLabel;   // Test name as scanned text

  logic    CLK;
  logic    RST;
  logic    instValid;
  mipsWord instData;
  logic    instCredit;
  logic    moveValid;
  oiscMove moveData;
  logic    moveCredit;

  mipsWord     instQ[$];
  logic [31:0] expQ[$];
  testLabel    expName[$];
  int          lineCount;
  int          instSent;
  int          creditsBack;
  int          movesSeen;
  int          creditsGiven;
  int          cycleCount;
  int          cycleLimit;
  integer      seed;

  tbClockGen i_clkGen (
    .CLK (CLK),
    .RST (RST)
  );

  mips2Oisc i_dut (
    .CLK        (CLK),
    .RST        (RST),
    .instValid  (instValid),
    .instData   (instData),
    .instCredit (instCredit),
    .moveValid  (moveValid),
    .moveData   (moveData),
    .moveCredit (moveCredit)
  );

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compareValue(input testLabel name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected)
      stopWithFailure($sformatf("Mismatch in test %0s: expected %h, actual %h",
                                name, expected, actual));
  endtask

  task automatic loadStimulus();
    int          fd;
    int          got;
    string       line;
    logic [7:0]  tag;
    testLabel    name;
    logic [31:0] value;
    fd = $fopen("mips2Oisc_stimulus.txt", "r");
    if (fd == 0)
      stopWithFailure("Cannot open the stimulus file mips2Oisc_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      if (got > 0 && line.len() > 1 && line[0] != "#") begin
        got = $sscanf(line, "%s %s %h", tag, name, value);
        if (got != 3)
          stopWithFailure($sformatf("Stimulus line cannot be parsed: %s", line));
        lineCount++;
        if (tag == "I") begin
          instQ.push_back(value);
        end else if (tag == "E") begin
          expQ.push_back(value);
          expName.push_back(name);
        end else begin
          stopWithFailure($sformatf("Stimulus line has an unknown tag: %s", line));
        end
      end
    end
    $fclose(fd);
  endtask

  // Sample the outputs and drive the next inputs on one falling edge
  task automatic serviceCycle();
    logic        sparse;
    testLabel    name;
    logic [31:0] expected;
    if (instCredit) begin
      creditsBack++;
      if (creditsBack > instSent)
        stopWithFailure("DUT returned more input credits than instructions sent");
    end
    if (moveValid) begin
      movesSeen++;
      if (movesSeen - creditsGiven > `OUT_CREDITS)
        stopWithFailure("DUT sent more moves than the output credits allow");
      if (expQ.size() == 0)
        stopWithFailure($sformatf("Move %h arrived when none was expected", moveData));
      expected = expQ.pop_front();
      name     = expName.pop_front();
      compareValue(name, expected, moveData);
    end

    instValid  = 1'b0;
    moveCredit = 1'b0;
    if (instQ.size() != 0 && instSent - creditsBack < `LANE_COUNT) begin
      instValid = 1'b1;
      instData  = instQ.pop_front();
      instSent++;
    end
    sparse = expName.size() != 0 && expName[0] == testLabel'("backpressure");
    if (movesSeen > creditsGiven && ($random(seed) & (sparse ? 7 : 1)) == 0) begin
      moveCredit = 1'b1;   // Sink frees one slot
      creditsGiven++;
    end
  endtask

  initial begin
    seed         = 32'hb513;
    instValid    = 1'b0;
    instData     = '0;
    moveCredit   = 1'b0;
    lineCount    = 0;
    instSent     = 0;
    creditsBack  = 0;
    movesSeen    = 0;
    creditsGiven = 0;
    cycleCount   = 0;
    loadStimulus();
    cycleLimit = 20 * lineCount + 200;

    wait (RST === 1'b1);
    wait (RST === 1'b0);

    while (instQ.size() != 0 || instSent != creditsBack) begin
      @(negedge CLK);
      serviceCycle();
      cycleCount++;
      if (cycleCount > cycleLimit)
        stopWithFailure($sformatf("Run timed out after %0d cycles with jobs in flight",
                                  cycleCount));
    end

    // Catch any stray move after the last job
    repeat (10) begin
      @(negedge CLK);
      serviceCycle();
    end

    if (expQ.size() != 0) begin
      stopWithFailure($sformatf("%0d expected moves never arrived, first one in test %0s",
                                expQ.size(), expName[0]));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

/* xlate_cfg.svh */
`ifndef XLATE_CFG_SVH
`define XLATE_CFG_SVH

// Sequencer lanes, also the input credits the source starts with
`define LANE_COUNT        2
`define OUT_CREDITS       4

// GPR n sits at GPR_BASE + n
`define GPR_BASE          16'h0020
`define IMM_ADDR          16'h0010
`define HI_ADDR           16'h0008
`define LO_ADDR           16'h0009

// Unit bases with accumulator at +0, second operand at +1 and control at +2
`define ADD_UNIT          16'h0100
`define AND_UNIT          16'h0110
`define OR_UNIT           16'h0120
`define XOR_UNIT          16'h0130
`define NOR_UNIT          16'h0140
`define SHIFT_UNIT        16'h0150

// MMU offset at +1, access control at +2 and read data at +3
`define MMU_BASE          16'h0200

`define TRAP_SRC          16'hFFFF
`define TRAP_DST          16'h000F

// Adder bit 1 selects subtract and bit 0 the overflow check
`define ADDER_ADD         16'b01
`define ADDER_ADDU        16'b00
`define ADDER_SUB         16'b11
`define ADDER_SUBU        16'b10

`define SHIFT_LEFT        16'b10
`define SHIFT_RIGHT_LOG   16'b00
`define SHIFT_RIGHT_ARITH 16'b01

// Bit 2 is signed and bits 1:0 the access size
`define LOAD_LB           16'b01100
`define LOAD_LBU          16'b01000
`define LOAD_LH           16'b01101
`define LOAD_LHU          16'b01001
`define LOAD_LW           16'b01010

`endif
